// File: sources.f
+incdir+tests
hdl/mem_pkg.sv
hdl/dmem_bank.sv
hdl/store_align.sv
hdl/wb_result_select.sv
hdl/mem_ctrl.sv
hdl/mem_stage.sv
tests/tb_mem_stage.sv

// File: tests/tb_mem_model.svh
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

// Byte-addressed model of the data memory
// Only the low address bits select a byte
localparam int MODEL_BYTES = 4 * DEPTH;
localparam int MODEL_ABITS = $clog2(MODEL_BYTES);

logic [7:0] ref_mem [MODEL_BYTES];

function automatic int access_bytes(input mem_pkg::mem_op_e op);
    if (op == mem_pkg::MEM_WORD) begin
        return 4;
    end else if (op == mem_pkg::MEM_HALF || op == mem_pkg::MEM_UHALF) begin
        return 2;
    end
    return 1;
endfunction

// Base address aligned down to the access width
function automatic int access_base(input mem_pkg::ex_mem_t rec);
    int a;
    a = int'(rec.alu_out[MODEL_ABITS-1:0]);
    return a - (a % access_bytes(rec.mem_op));
endfunction

function automatic void ref_store(input mem_pkg::ex_mem_t rec, input logic [31:0] data);
    int a;
    int i;
    a = access_base(rec);
    for (i = 0; i < access_bytes(rec.mem_op); i++) begin
        ref_mem[a + i] = data[8 * i +: 8];
    end
endfunction

function automatic logic [31:0] ref_load(input mem_pkg::ex_mem_t rec);
    int a;
    int n;
    int i;
    logic [31:0] v;
    logic sign;
    a = access_base(rec);
    n = access_bytes(rec.mem_op);
    v = '0;
    for (i = 0; i < n; i++) begin
        v[8 * i +: 8] = ref_mem[a + i];
    end
    // Only the signed narrow loads copy the top bit upward
    sign = (rec.mem_op == mem_pkg::MEM_BYTE || rec.mem_op == mem_pkg::MEM_HALF)
           && ref_mem[a + n - 1][7];
    for (i = n; i < 4; i++) begin
        v[8 * i +: 8] = {8{sign}};
    end
    return v;
endfunction

// Applies one accepted record to the model and returns its MEM/WB record
function automatic mem_pkg::mem_wb_t expected_result(input mem_pkg::ex_mem_t rec,
        input logic fwd, input logic [31:0] fdata);
    mem_pkg::mem_wb_t r;
    r.is_load   = rec.mem_read;
    r.read_data = rec.mem_read ? ref_load(rec) : 32'h0000_0000;
    r.reg_data  = (rec.wb_src == mem_pkg::WB_PC_INC) ? rec.pc_inc :
                  (rec.wb_src == mem_pkg::WB_IMM)    ? rec.imm    : rec.alu_out;
    r.rd        = rec.rd;
    if (rec.mem_write) begin
        ref_store(rec, fwd ? fdata : rec.store_data);
    end
    return r;
endfunction

`endif

// File: tests/tb_mem_stage.sv
`timescale 1ns/10ps

module tb_mem_stage;

    localparam int DEPTH = 64;
    localparam int RESET_CYCLES = 10;
    localparam int N_DIRECTED = 120;
    localparam int N_RANDOM = 600;
    // Budget of 20 cycles per record
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + (DEPTH + N_DIRECTED + N_RANDOM) * 20;

    logic             clk;
    logic             reset;
    logic             in_valid;
    mem_pkg::ex_mem_t in_rec;
    logic             wb_forward;
    logic [31:0]      wb_data;
    logic             stall_mem;
    logic             out_valid;
    mem_pkg::mem_wb_t out_rec;
    logic             out_ready;

    mem_pkg::mem_wb_t exp_q[$];
    string            name_q[$];
    int               mismatch_count = 0;
    int               other_count = 0;

    `include "tb_mem_model.svh"

    mem_stage #(.DEPTH(DEPTH)) dut0 (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_rec     (in_rec),
        .wb_forward (wb_forward),
        .wb_data    (wb_data),
        .stall_mem  (stall_mem),
        .out_valid  (out_valid),
        .out_rec    (out_rec),
        .out_ready  (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic mem_pkg::ex_mem_t make_rec(input logic rd_en, input logic wr_en,
            input mem_pkg::mem_op_e op, input logic [31:0] addr, input logic [31:0] sdata,
            input mem_pkg::wb_src_e src);
        mem_pkg::ex_mem_t rec;
        rec.mem_read   = rd_en;
        rec.mem_write  = wr_en;
        rec.mem_op     = op;
        rec.wb_src     = src;
        rec.alu_out    = addr;
        rec.store_data = sdata;
        rec.imm        = $urandom();
        rec.pc_inc     = $urandom();
        rec.rd         = 5'($urandom());
        return rec;
    endfunction

    function automatic mem_pkg::ex_mem_t random_rec();
        int kind;
        int op;
        kind = $urandom_range(0, 2);
        // Stores only use the signed widths
        op = (kind == 2) ? $urandom_range(0, 2) : $urandom_range(0, 4);
        return make_rec(kind == 1, kind == 2, mem_pkg::mem_op_e'(op), $urandom(), $urandom(),
                        mem_pkg::wb_src_e'($urandom_range(0, 2)));
    endfunction

    // Holds the record until accepted, then logs its expected result
    task automatic issue_record(input string name, input mem_pkg::ex_mem_t rec,
            input logic fwd, input logic [31:0] fdata);
        in_valid   = 1'b1;
        in_rec     = rec;
        wb_forward = fwd;
        wb_data    = fdata;
        @(negedge clk);
        while (stall_mem) begin
            @(negedge clk);
        end
        exp_q.push_back(expected_result(in_rec, wb_forward, wb_data));
        name_q.push_back(name);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    // Directed record with the ALU output as register result
    task automatic send(input string name, input logic rd_en, input logic wr_en, input int op,
            input logic [31:0] addr, input logic fwd, input logic [31:0] fdata);
        issue_record(name, make_rec(rd_en, wr_en, mem_pkg::mem_op_e'(op), addr, ~fdata,
                     mem_pkg::WB_ALU), fwd, fdata);
    endtask

    task automatic drive_ready();
        int step;
        step = 0;
        forever begin
            @(posedge clk);
            #1;
            // 80 random cycles, 25 low, 40 high, then 30 toggling
            if (step < 80) begin
                out_ready = 1'($urandom_range(0, 1));
            end else if (step < 105) begin
                out_ready = 1'b0;
            end else if (step < 145) begin
                out_ready = 1'b1;
            end else begin
                out_ready = !out_ready;
            end
            step = (step + 1) % 175;
        end
    endtask

    initial begin : stimulus
        int i;
        int j;
        logic [31:0] addr;
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_rec     = '0;
        wb_forward = 1'b0;
        wb_data    = '0;
        out_ready  = 1'b0;
        void'($urandom(18406));
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        fork
            drive_ready();
        join_none
        @(negedge clk);
        assert (!stall_mem && !out_valid) else begin
            other_count++;
            $display("stall_mem or out_valid is high after reset");
        end
        @(posedge clk);
        #1;
        // Every word gets a known value before any load
        for (i = 0; i < DEPTH; i++) begin
            send("word_fill", 1'b0, 1'b1, mem_pkg::MEM_WORD, i * 4, 1'b1, $urandom());
        end
        for (i = 0; i < 8; i++) begin
            addr = $urandom_range(0, DEPTH - 1) * 4;
            send("word_rw", 1'b0, 1'b1, mem_pkg::MEM_WORD, addr, 1'b1, $urandom());
            send("word_rw", 1'b1, 1'b0, mem_pkg::MEM_WORD, addr, 1'b0, 0);
            send("word_rw", 1'b1, 1'b0, mem_pkg::MEM_WORD, $urandom(), 1'b0, 0);
        end
        for (i = 0; i < 4; i++) begin
            send("sub_word", 1'b0, 1'b1, mem_pkg::MEM_BYTE, 20 + i, 1'b1, 32'hC3 + i);
            send("sub_word", 1'b1, 1'b0, mem_pkg::MEM_WORD, 20, 1'b0, 0);
        end
        // Odd offsets check that address bit 0 is ignored
        for (i = 1; i < 4; i += 2) begin
            send("sub_word", 1'b0, 1'b1, mem_pkg::MEM_HALF, 24 + i, 1'b1, 32'h5A00 + i);
            send("sub_word", 1'b1, 1'b0, mem_pkg::MEM_WORD, 24, 1'b0, 0);
        end
        send("load_extend", 1'b0, 1'b1, mem_pkg::MEM_WORD, 32, 1'b1, 32'h807F_01FF);
        send("load_extend", 1'b0, 1'b1, mem_pkg::MEM_WORD, 36, 1'b1, 32'h7F80_FF01);
        for (i = 0; i < 5; i++) begin
            for (j = 0; j < 8; j++) begin
                send("load_extend", 1'b1, 1'b0, i, 32 + j, 1'b0, 0);
            end
        end
        // Each result source with no access, a load and a store
        for (i = 0; i < 3; i++) begin
            for (j = 0; j < 3; j++) begin
                issue_record("wb_src", make_rec(j == 1, j == 2, mem_pkg::MEM_WORD, $urandom(),
                             $urandom(), mem_pkg::wb_src_e'(i)), 1'b0, 0);
            end
        end
        for (i = 0; i < 8; i++) begin
            addr = $urandom();
            j    = $urandom_range(0, 2);
            // Register operand is the inverse so that a missed forward shows up
            send("forward", 1'b0, 1'b1, j, addr, 1'b1, $urandom());
            send("forward", 1'b1, 1'b0, j, addr, 1'b0, 0);
        end
        for (i = 0; i < N_RANDOM; i++) begin
            if ($urandom_range(0, 7) == 0) begin
                @(posedge clk);
                #1;
            end
            issue_record("random", random_rec(), 1'($urandom_range(0, 1)), $urandom());
        end
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(negedge clk);
        assert (!out_valid) else begin
            other_count++;
            $display("out_valid is still high after the last expected record");
        end
        $display("mismatches: %0d, other errors: %0d", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin : compare
        mem_pkg::mem_wb_t exp_rec;
        mem_pkg::mem_wb_t held;
        logic held_valid;
        string name;
        held_valid = 1'b0;
        forever begin
            @(negedge clk);
            if (held_valid && out_valid) begin
                assert (out_rec == held) else begin
                    other_count++;
                    $display("out_rec changed while out_valid was high and out_ready low");
                end
            end
            held_valid = 1'b0;
            if (!reset && out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    other_count++;
                    $display("output transfer with no accepted record pending");
                end else begin
                    exp_rec = exp_q.pop_front();
                    name    = name_q.pop_front();
                    assert (out_rec == exp_rec) else begin
                        mismatch_count++;
                        $display("mismatch %s: expected %h actual %h", name, exp_rec, out_rec);
                    end
                end
            end else if (!reset && out_valid) begin
                held       = out_rec;
                held_valid = 1'b1;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("mismatches: %0d, other errors: %0d", mismatch_count, other_count + 1);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: hdl/mem_stage.sv
`timescale 1ns/10ps

module mem_stage #(
    parameter int DEPTH = 1024
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  mem_pkg::ex_mem_t in_rec,
    input  logic             wb_forward,
    input  logic [31:0]      wb_data,
    output logic             stall_mem,
    output logic             out_valid,
    output mem_pkg::mem_wb_t out_rec,
    input  logic             out_ready
);

    mem_pkg::lane_req_t       lane_req;
    logic [3:0]               bank_we;
    logic [3:0]               bank_re;
    logic [$clog2(DEPTH)-1:0] word_index;
    logic [31:0]              bank_rdata;
    mem_pkg::slot_t           next_slot;
    mem_pkg::slot_t           cur_slot;
    logic [31:0]              load_data;

    mem_ctrl ctrl0 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .stall_mem (stall_mem),
        .lane_req  (lane_req),
        .bank_we   (bank_we),
        .bank_re   (bank_re),
        .next_slot (next_slot),
        .cur_slot  (cur_slot),
        .load_data (load_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_rec   (out_rec)
    );

    store_align #(
        .DEPTH (DEPTH)
    ) align0 (
        .in_rec     (in_rec),
        .wb_forward (wb_forward),
        .wb_data    (wb_data),
        .lane_req   (lane_req),
        .word_index (word_index)
    );

    wb_result_select sel0 (
        .in_rec     (in_rec),
        .next_slot  (next_slot),
        .cur_slot   (cur_slot),
        .bank_rdata (bank_rdata),
        .load_data  (load_data)
    );

    // Byte lanes with bank0 at address offset 0
    dmem_bank #(.DEPTH(DEPTH)) bank0 (
        .clk   (clk),
        .reset (reset),
        .index (word_index),
        .re    (bank_re[0]),
        .we    (bank_we[0]),
        .wdata (lane_req.wdata[7:0]),
        .rdata (bank_rdata[7:0])
    );

    dmem_bank #(.DEPTH(DEPTH)) bank1 (
        .clk   (clk),
        .reset (reset),
        .index (word_index),
        .re    (bank_re[1]),
        .we    (bank_we[1]),
        .wdata (lane_req.wdata[15:8]),
        .rdata (bank_rdata[15:8])
    );

    dmem_bank #(.DEPTH(DEPTH)) bank2 (
        .clk   (clk),
        .reset (reset),
        .index (word_index),
        .re    (bank_re[2]),
        .we    (bank_we[2]),
        .wdata (lane_req.wdata[23:16]),
        .rdata (bank_rdata[23:16])
    );

    dmem_bank #(.DEPTH(DEPTH)) bank3 (
        .clk   (clk),
        .reset (reset),
        .index (word_index),
        .re    (bank_re[3]),
        .we    (bank_we[3]),
        .wdata (lane_req.wdata[31:24]),
        .rdata (bank_rdata[31:24])
    );

endmodule

// File: hdl/mem_ctrl.sv
`timescale 1ns/10ps

module mem_ctrl (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    output logic               stall_mem,
    input  mem_pkg::lane_req_t lane_req,
    output logic [3:0]         bank_we,
    output logic [3:0]         bank_re,
    input  mem_pkg::slot_t     next_slot,
    output mem_pkg::slot_t     cur_slot,
    input  logic [31:0]        load_data,
    output logic               out_valid,
    input  logic               out_ready,
    output mem_pkg::mem_wb_t   out_rec
);

    // Access slot holds the record whose bank access happened at the last accept
    logic           acc_valid;
    mem_pkg::slot_t acc_slot;

    logic res_free;
    logic advance;
    logic accept;

    // Result slot can take a new record when empty or being consumed
    assign res_free = !out_valid || out_ready;
    assign advance  = acc_valid && res_free;

    // Both slots full and downstream not taking the result
    assign stall_mem = acc_valid && !res_free;
    assign accept    = in_valid && !stall_mem;

    // Banks are only touched for an accepted record, which keeps the
    // read registers of a held load intact during a stall
    assign bank_we = accept ? lane_req.we : 4'b0000;
    assign bank_re = accept ? lane_req.re : 4'b0000;

    assign cur_slot = acc_slot;

    always_ff @(posedge clk) begin
        if (reset) begin
            acc_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            // Without a stall the access slot either advances or was empty
            if (!stall_mem) begin
                acc_valid <= accept;
            end
            if (res_free) begin
                out_valid <= acc_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            acc_slot <= next_slot;
        end
    end

    // load_data is taken from the bank registers filled at accept time
    always_ff @(posedge clk) begin
        if (advance) begin
            out_rec.is_load   <= acc_slot.is_load;
            out_rec.read_data <= acc_slot.is_load ? load_data : 32'h0000_0000;
            out_rec.reg_data  <= acc_slot.reg_data;
            out_rec.rd        <= acc_slot.rd;
        end
    end

endmodule

// File: hdl/wb_result_select.sv
`timescale 1ns/10ps

module wb_result_select (
    input  mem_pkg::ex_mem_t in_rec,
    output mem_pkg::slot_t   next_slot,
    input  mem_pkg::slot_t   cur_slot,
    input  logic [31:0]      bank_rdata,
    output logic [31:0]      load_data
);

    logic [31:0] reg_result;
    logic [7:0]  byte_val;
    logic [15:0] half_val;

    // Non-load result is the JAL link value, the LUI immediate or the ALU output
    always_comb begin
        case (in_rec.wb_src)
            mem_pkg::WB_PC_INC: reg_result = in_rec.pc_inc;
            mem_pkg::WB_IMM:    reg_result = in_rec.imm;
            default:            reg_result = in_rec.alu_out;
        endcase
    end

    assign next_slot.is_load  = in_rec.mem_read;
    assign next_slot.mem_op   = in_rec.mem_op;
    assign next_slot.offset   = in_rec.alu_out[1:0];
    assign next_slot.reg_data = reg_result;
    assign next_slot.rd       = in_rec.rd;

    // Bank outputs belong to the record in the access slot
    assign byte_val = bank_rdata[{cur_slot.offset, 3'b000} +: 8];
    assign half_val = cur_slot.offset[1] ? bank_rdata[31:16] : bank_rdata[15:0];

    always_comb begin
        case (cur_slot.mem_op)
            mem_pkg::MEM_BYTE: begin
                load_data = {{24{byte_val[7]}}, byte_val};
            end
            mem_pkg::MEM_UBYTE: begin
                load_data = {24'h000000, byte_val};
            end
            mem_pkg::MEM_HALF: begin
                load_data = {{16{half_val[15]}}, half_val};
            end
            mem_pkg::MEM_UHALF: begin
                load_data = {16'h0000, half_val};
            end
            default: begin
                load_data = bank_rdata;
            end
        endcase
    end

endmodule

// File: hdl/store_align.sv
`timescale 1ns/10ps

module store_align #(
    parameter int DEPTH = 1024
) (
    input  mem_pkg::ex_mem_t         in_rec,
    input  logic                     wb_forward,
    input  logic [31:0]              wb_data,
    output mem_pkg::lane_req_t       lane_req,
    output logic [$clog2(DEPTH)-1:0] word_index
);

    logic [31:0] store_src;
    logic [1:0]  offset;
    logic [3:0]  lane_mask;
    logic [3:0]  half_mask;
    logic [31:0] lane_wdata;
    logic        write_op;

    // Forwarded write-back value overrides a stale register operand
    assign store_src  = wb_forward ? wb_data : in_rec.store_data;
    assign offset     = in_rec.alu_out[1:0];
    assign word_index = in_rec.alu_out[2 +: $clog2(DEPTH)];

    // Halfwords ignore address bit 0
    assign half_mask = offset[1] ? 4'b1100 : 4'b0011;

    always_comb begin
        lane_mask  = 4'b0000;
        lane_wdata = store_src;
        write_op   = 1'b0;
        case (in_rec.mem_op)
            mem_pkg::MEM_BYTE: begin
                lane_mask  = 4'b0001 << offset;
                lane_wdata = {4{store_src[7:0]}};
                write_op   = 1'b1;
            end
            mem_pkg::MEM_UBYTE: begin
                lane_mask = 4'b0001 << offset;
            end
            mem_pkg::MEM_HALF: begin
                lane_mask  = half_mask;
                lane_wdata = {2{store_src[15:0]}};
                write_op   = 1'b1;
            end
            mem_pkg::MEM_UHALF: begin
                lane_mask = half_mask;
            end
            mem_pkg::MEM_WORD: begin
                lane_mask = 4'b1111;
                write_op  = 1'b1;
            end
            default: begin
                lane_mask = 4'b0000;
            end
        endcase
    end

    // Unsigned opcodes only exist for loads, so they never write
    assign lane_req.we    = (in_rec.mem_write && write_op) ? lane_mask : 4'b0000;
    assign lane_req.re    = in_rec.mem_read ? lane_mask : 4'b0000;
    assign lane_req.wdata = lane_wdata;

endmodule

// File: hdl/dmem_bank.sv
`timescale 1ns/10ps

module dmem_bank #(
    parameter int DEPTH = 1024
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [$clog2(DEPTH)-1:0] index,
    input  logic                     re,
    input  logic                     we,
    input  logic [7:0]               wdata,
    output logic [7:0]               rdata
);

    // One byte lane of the data memory
    logic [7:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
    end

    // Read register holds its byte until the next enabled read
    // A read together with a write on the same edge returns the old byte
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata <= 8'h00;
        end else if (re) begin
            rdata <= mem[index];
        end
    end

endmodule

// File: hdl/mem_pkg.sv
package mem_pkg;

    // Access width and signedness of a load or store
    typedef enum logic [2:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD,
        MEM_UBYTE,
        MEM_UHALF
    } mem_op_e;

    // Where the non-load register result comes from
    typedef enum logic [1:0] {
        WB_ALU,
        WB_PC_INC,
        WB_IMM
    } wb_src_e;

    // Record handed over by the execute stage
    typedef struct packed {
        logic        mem_read;
        logic        mem_write;
        mem_op_e     mem_op;
        wb_src_e     wb_src;
        logic [31:0] alu_out;
        logic [31:0] store_data;
        logic [31:0] imm;
        logic [31:0] pc_inc;
        logic [4:0]  rd;
    } ex_mem_t;

    // One bit per byte lane
    // Bank 0 holds the lowest byte
    typedef struct packed {
        logic [3:0]  we;
        logic [3:0]  re;
        logic [31:0] wdata;
    } lane_req_t;

    // Access slot contents kept until the bank data is back
    typedef struct packed {
        logic        is_load;
        mem_op_e     mem_op;
        logic [1:0]  offset;
        logic [31:0] reg_data;
        logic [4:0]  rd;
    } slot_t;

    typedef struct packed {
        logic        is_load;
        logic [31:0] read_data;
        logic [31:0] reg_data;
        logic [4:0]  rd;
    } mem_wb_t;

endpackage
